// ==== common/ahb_pkg.sv ====
// AHB protocol package with the bus field types and their encodings
`default_nettype none

package ahb_pkg;

  // ----------------------------------------------------------------------
  // Field types
  // ----------------------------------------------------------------------

  typedef logic [1:0] htrans_t;   // HTRANS transfer type
  typedef logic [2:0] hburst_t;   // HBURST burst type
  typedef logic [1:0] hresp_t;    // HRESP slave response
  typedef logic [2:0] hsize_t;    // HSIZE, log2 of bytes per beat
  typedef logic [3:0] hprot_t;    // HPROT protection bits

  // ----------------------------------------------------------------------
  // HTRANS encoding
  // ----------------------------------------------------------------------

  localparam htrans_t TRN_IDLE   = 2'b00;  // No transfer
  localparam htrans_t TRN_BUSY   = 2'b01;  // Master inserts a wait in a burst
  localparam htrans_t TRN_NONSEQ = 2'b10;  // First beat or single
  localparam htrans_t TRN_SEQ    = 2'b11;  // Following beat of a burst

  // ----------------------------------------------------------------------
  // HBURST encoding
  // ----------------------------------------------------------------------

  // Bit 0 set means incrementing, upper bits give the length
  localparam hburst_t BUR_SINGLE = 3'b000;  // Single beat
  localparam hburst_t BUR_INCR   = 3'b001;  // Undefined length incr
  localparam hburst_t BUR_WRAP4  = 3'b010;  // 4-beat wrap
  localparam hburst_t BUR_INCR4  = 3'b011;  // 4-beat incr
  localparam hburst_t BUR_WRAP8  = 3'b100;  // 8-beat wrap
  localparam hburst_t BUR_INCR8  = 3'b101;  // 8-beat incr
  localparam hburst_t BUR_WRAP16 = 3'b110;  // 16-beat wrap
  localparam hburst_t BUR_INCR16 = 3'b111;  // 16-beat incr

  // HRESP encoding
  localparam hresp_t RSP_OKAY  = 2'b00;   // Transfer completed fine
  localparam hresp_t RSP_ERROR = 2'b01;   // Two-cycle error response

endpackage

`default_nettype wire

// ==== common/instage_pkg.sv ====
// Input stage package with the internal types of the boundary logic
`default_nettype none

package instage_pkg;

  // ----------------------------------------------------------------------
  // Wrap boundary support
  // ----------------------------------------------------------------------

  // Beat index inside a 16-beat window
  // Wide enough for the longest wrapping burst (WRAP16)
  typedef logic [3:0] beat_offset_t;

  // Largest HSIZE with its own address slice
  // 3 is a 64-bit beat, so the slice tops out at address bit 6
  // Wider beats fall back to the byte slice
  localparam ahb_pkg::hsize_t MAX_SIZE = 3'd3;

  // Offset of the last beat in a full 16-beat window
  localparam beat_offset_t LAST_BEAT = 4'hf;

endpackage

`default_nettype wire

// ==== rtl/instage_pend_ctrl.sv ====
// Input stage control with the load decode, pending flag and slave response
`default_nettype none
`timescale 1ns/1ps

module instage_pend_ctrl (
  input  logic             HCLK,
  input  logic             HRESETn,
  input  logic             HSELS,
  input  ahb_pkg::htrans_t HTRANSS,
  input  logic             HREADYS,
  input  logic             active_ip,      // Output stage drives this port
  input  logic             readyout_ip,    // HREADYOUT of the shared slave
  input  ahb_pkg::hresp_t  resp_ip,        // HRESP of the shared slave
  output logic             load_reg,       // Accepted beat, capture it
  output logic             pend_tran_reg,  // Beat waits in the register
  output logic             held_tran_ip,   // Request to the arbiters
  output logic             HREADYOUTS,
  output ahb_pkg::hresp_t  HRESPS
);

  import ahb_pkg::*;

  logic addr_valid;   // NONSEQ or SEQ to this port
  logic data_valid;   // Data phase of such a beat
  logic pend_tran;    // Next value of pend_tran_reg

  // ----------------------------------------------------------------------
  // Address phase decode
  // ----------------------------------------------------------------------

  assign addr_valid = HSELS & HTRANSS[1];     // IDLE and BUSY excluded
  assign load_reg   = addr_valid & HREADYS;   // Master moves on this edge

  // Tracks the data phase, steps only when the bus advances
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_valid <= 1'b0;
    else if (HREADYS)
      data_valid <= addr_valid;
  end

  // ----------------------------------------------------------------------
  // Pending transfer
  // ----------------------------------------------------------------------

  // Set when the output stage misses the beat
  // Clear once it is driven and the slave completes it
  assign pend_tran = (load_reg && !active_ip)    ? 1'b1 :
                     (active_ip && readyout_ip) ? 1'b0 :
                                                  pend_tran_reg;

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      pend_tran_reg <= 1'b0;
    else
      pend_tran_reg <= pend_tran;
  end

  // Direct beat this cycle or held beat from earlier
  assign held_tran_ip = load_reg | pend_tran_reg;

  // Response to the master
  always_comb
  begin
    if (!data_valid)
    begin
      HREADYOUTS = 1'b1;          // Nothing owed, zero-wait OKAY
      HRESPS     = RSP_OKAY;
    end
    else if (pend_tran_reg)
    begin
      HREADYOUTS = 1'b0;          // Stall until the held beat goes out
      HRESPS     = RSP_OKAY;
    end
    else
    begin
      HREADYOUTS = readyout_ip;
      HRESPS     = resp_ip;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/instage_hold_regs.sv ====
// Input stage holding register with the held/direct address path mux
`default_nettype none
`timescale 1ns/1ps

module instage_hold_regs #(
  parameter int ADDR_WIDTH   = 32,
  parameter int MASTER_WIDTH = 4
) (
  input  logic                    HCLK,
  input  logic                    HRESETn,
  input  logic                    load_reg,       // Capture this beat
  input  logic                    pend_tran_reg,  // Drive from the register

  // Direct address and control from the slave port
  input  logic                    HSELS,
  input  logic [ADDR_WIDTH-1:0]   HADDRS,
  input  ahb_pkg::htrans_t        HTRANSS,
  input  logic                    HWRITES,
  input  ahb_pkg::hsize_t         HSIZES,
  input  ahb_pkg::hburst_t        HBURSTS,
  input  ahb_pkg::hprot_t         HPROTS,
  input  logic [MASTER_WIDTH-1:0] HMASTERS,
  input  logic                    HMASTLOCKS,

  // Selected path towards the output stage
  output logic                    sel_ip,
  output logic [ADDR_WIDTH-1:0]   addr_ip,
  output logic                    write_ip,
  output ahb_pkg::hsize_t         size_ip,
  output ahb_pkg::hprot_t         prot_ip,
  output logic [MASTER_WIDTH-1:0] master_ip,
  output logic                    mastlock_ip,
  output ahb_pkg::htrans_t        trans_int,      // Before burst rewrite
  output ahb_pkg::htrans_t        transb,         // Original beat type
  output ahb_pkg::hburst_t        burst_int       // Before burst rewrite
);

  import ahb_pkg::*;

  // Captured beat
  htrans_t                 reg_trans;
  hburst_t                 reg_burst;
  logic                    reg_mastlock;
  logic [ADDR_WIDTH-1:0]   reg_addr;
  logic                    reg_write;
  hsize_t                  reg_size;
  hprot_t                  reg_prot;
  logic [MASTER_WIDTH-1:0] reg_master;

  // ----------------------------------------------------------------------
  // Capture on every accepted beat
  // ----------------------------------------------------------------------

  // Beat type, burst and lock steer the output stage
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      reg_trans    <= TRN_IDLE;
      reg_burst    <= BUR_SINGLE;
      reg_mastlock <= 1'b0;
    end
    else if (load_reg)
    begin
      reg_trans    <= HTRANSS;
      reg_burst    <= HBURSTS;
      reg_mastlock <= HMASTLOCKS;
    end
  end

  always_ff @(posedge HCLK)
  begin
    if (load_reg)
    begin
      reg_addr   <= HADDRS;
      reg_write  <= HWRITES;
      reg_size   <= HSIZES;
      reg_prot   <= HPROTS;
      reg_master <= HMASTERS;
    end
  end

  // ----------------------------------------------------------------------
  // Held or direct path
  // ----------------------------------------------------------------------

  always_comb
  begin
    if (pend_tran_reg)
    begin
      sel_ip      = 1'b1;         // Held beat always targets us
      trans_int   = TRN_NONSEQ;   // Replayed as a fresh transfer
      transb      = reg_trans;
      addr_ip     = reg_addr;
      write_ip    = reg_write;
      size_ip     = reg_size;
      burst_int   = reg_burst;
      prot_ip     = reg_prot;
      master_ip   = reg_master;
      mastlock_ip = reg_mastlock;
    end
    else
    begin
      sel_ip      = HSELS;        // Straight through
      trans_int   = HTRANSS;
      transb      = HTRANSS;
      addr_ip     = HADDRS;
      write_ip    = HWRITES;
      size_ip     = HSIZES;
      burst_int   = HBURSTS;
      prot_ip     = HPROTS;
      master_ip   = HMASTERS;
      mastlock_ip = HMASTLOCKS;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/instage_burst_term.sv ====
// Input stage early burst termination, keeps an interrupted burst legal AHB
`default_nettype none
`timescale 1ns/1ps

module instage_burst_term #(
  parameter int ADDR_WIDTH = 32   // At least 7
) (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  ahb_pkg::htrans_t      HTRANSS,
  input  logic [ADDR_WIDTH-1:0] HADDRS,
  input  ahb_pkg::hsize_t       HSIZES,
  input  ahb_pkg::hburst_t      HBURSTS,
  input  logic                  HREADYS,
  input  logic                  load_reg,    // Accepted beat
  input  logic                  active_ip,   // Output stage drives this port
  input  ahb_pkg::htrans_t      trans_int,   // Held or direct HTRANS
  input  ahb_pkg::htrans_t      transb,      // Original HTRANS of the beat
  input  ahb_pkg::hburst_t      burst_int,   // Held or direct HBURST
  output ahb_pkg::htrans_t      trans_ip,
  output ahb_pkg::hburst_t      burst_ip
);

  import ahb_pkg::*;
  import instage_pkg::*;

  logic         burst_override;   // Burst was cut, finish it as INCR
  logic         override_next;
  beat_offset_t offset_addr;      // Beat index from the address
  beat_offset_t check_addr;       // Offset padded to the wrap window
  logic         bound;            // Previous beat closed the wrap window
  logic         bound_next;
  logic         bound_en;

  // ----------------------------------------------------------------------
  // Override flag
  // ----------------------------------------------------------------------

  // A SEQ beat the output stage did not take breaks the fixed burst
  // A new NONSEQ or IDLE ends the broken burst
  always_comb
  begin
    if (HTRANSS == TRN_NONSEQ || HTRANSS == TRN_IDLE)
      override_next = 1'b0;
    else if (HTRANSS == TRN_SEQ && load_reg && !active_ip)
      override_next = 1'b1;
    else
      override_next = burst_override;  // BUSY keeps state
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      burst_override <= 1'b0;
    else if (HREADYS)
      burst_override <= override_next;
  end

  // ----------------------------------------------------------------------
  // Wrap boundary detection
  // ----------------------------------------------------------------------

  // Address bits that count beats for this size
  always_comb
  begin
    if (HSIZES <= MAX_SIZE)
      offset_addr = HADDRS[HSIZES +: 4];
    else
      offset_addr = HADDRS[3:0];       // 128-bit and up, byte slice
  end

  // Bits above the window forced high, INCR and SINGLE never match
  always_comb
  begin
    case (HBURSTS)
      BUR_WRAP4  : check_addr = {2'b11, offset_addr[1:0]};
      BUR_WRAP8  : check_addr = {1'b1, offset_addr[2:0]};
      BUR_WRAP16 : check_addr = offset_addr;
      default    : check_addr = '0;
    endcase
  end

  assign bound_next = (check_addr == LAST_BEAT);
  assign bound_en   = HTRANSS[1] & HREADYS;   // Only on real beats

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      bound <= 1'b0;
    else if (bound_en)
      bound <= bound_next;
  end

  // Rewrite
  // SEQ becomes NONSEQ and BUSY becomes IDLE after the wrap point
  assign trans_ip = (burst_override && bound) ? {trans_int[1], 1'b0} : trans_int;

  // Remaining beats run as undefined length
  assign burst_ip = (burst_override && transb != TRN_NONSEQ) ? BUR_INCR : burst_int;

endmodule

`default_nettype wire

// ==== rtl/ahb_input_stage.sv ====
// AHB matrix input stage, holds a transfer the output stage cannot take yet
`default_nettype none
`timescale 1ns/1ps

module ahb_input_stage #(
  parameter int ADDR_WIDTH   = 32,  // At least 7 for the 64-bit offset slice
  parameter int MASTER_WIDTH = 4
) (
  input  logic                    HCLK,
  input  logic                    HRESETn,

  // Slave port from the master side
  input  logic                    HSELS,
  input  logic [ADDR_WIDTH-1:0]   HADDRS,
  input  ahb_pkg::htrans_t        HTRANSS,
  input  logic                    HWRITES,
  input  ahb_pkg::hsize_t         HSIZES,
  input  ahb_pkg::hburst_t        HBURSTS,
  input  ahb_pkg::hprot_t         HPROTS,
  input  logic [MASTER_WIDTH-1:0] HMASTERS,
  input  logic                    HMASTLOCKS,
  input  logic                    HREADYS,
  output logic                    HREADYOUTS,
  output ahb_pkg::hresp_t         HRESPS,

  // Internal port towards the output stages
  output logic                    sel_ip,
  output logic [ADDR_WIDTH-1:0]   addr_ip,
  output ahb_pkg::htrans_t        trans_ip,
  output logic                    write_ip,
  output ahb_pkg::hsize_t         size_ip,
  output ahb_pkg::hburst_t        burst_ip,
  output ahb_pkg::hprot_t         prot_ip,
  output logic [MASTER_WIDTH-1:0] master_ip,
  output logic                    mastlock_ip,
  output logic                    held_tran_ip,  // Request to the arbiters
  input  logic                    active_ip,     // Output stage drives this port
  input  logic                    readyout_ip,
  input  ahb_pkg::hresp_t         resp_ip
);

  import ahb_pkg::*;

  logic    load_reg;        // Valid beat accepted this cycle
  logic    pend_tran_reg;   // Holding register in use
  htrans_t trans_int;       // Held or direct HTRANS before rewrite
  htrans_t transb;          // HTRANS for the burst rewrite decision
  hburst_t burst_int;       // Held or direct HBURST before rewrite

  // ----------------------------------------------------------------------
  // Flags and response
  // ----------------------------------------------------------------------

  instage_pend_ctrl pend_ctrl_i (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .HSELS         (HSELS),
    .HTRANSS       (HTRANSS),
    .HREADYS       (HREADYS),
    .active_ip     (active_ip),
    .readyout_ip   (readyout_ip),
    .resp_ip       (resp_ip),
    .load_reg      (load_reg),
    .pend_tran_reg (pend_tran_reg),
    .held_tran_ip  (held_tran_ip),
    .HREADYOUTS    (HREADYOUTS),
    .HRESPS        (HRESPS)
  );

  // ----------------------------------------------------------------------
  // Holding register and path mux
  // ----------------------------------------------------------------------

  instage_hold_regs #(
    .ADDR_WIDTH   (ADDR_WIDTH),
    .MASTER_WIDTH (MASTER_WIDTH)
  ) hold_regs_i (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .load_reg      (load_reg),
    .pend_tran_reg (pend_tran_reg),
    .HSELS         (HSELS),
    .HADDRS        (HADDRS),
    .HTRANSS       (HTRANSS),
    .HWRITES       (HWRITES),
    .HSIZES        (HSIZES),
    .HBURSTS       (HBURSTS),
    .HPROTS        (HPROTS),
    .HMASTERS      (HMASTERS),
    .HMASTLOCKS    (HMASTLOCKS),
    .sel_ip        (sel_ip),
    .addr_ip       (addr_ip),
    .write_ip      (write_ip),
    .size_ip       (size_ip),
    .prot_ip       (prot_ip),
    .master_ip     (master_ip),
    .mastlock_ip   (mastlock_ip),
    .trans_int     (trans_int),
    .transb        (transb),
    .burst_int     (burst_int)
  );

  // Early burst termination
  instage_burst_term #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) burst_term_i (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HTRANSS   (HTRANSS),
    .HADDRS    (HADDRS),
    .HSIZES    (HSIZES),
    .HBURSTS   (HBURSTS),
    .HREADYS   (HREADYS),
    .load_reg  (load_reg),
    .active_ip (active_ip),
    .trans_int (trans_int),
    .transb    (transb),
    .burst_int (burst_int),
    .trans_ip  (trans_ip),
    .burst_ip  (burst_ip)
  );

endmodule

`default_nettype wire

// ==== dv/tb_ahb_input_stage.sv ====
// Testbench for the AHB input stage that checks the DUT against a behavioral model
`default_nettype none
`timescale 1ns/1ps

module tb_ahb_input_stage;

  import ahb_pkg::*;

  localparam int unsigned CYCLE_LIMIT = 1200;  // About twice the stimulus length

  logic        HCLK = 1'b0;
  logic        HRESETn;
  logic        HSELS, HWRITES, HMASTLOCKS, HREADYS, HREADYOUTS;
  logic [31:0] HADDRS, addr_ip;
  htrans_t     HTRANSS, trans_ip;
  hsize_t      HSIZES, size_ip;
  hburst_t     HBURSTS, burst_ip;
  hprot_t      HPROTS, prot_ip;
  logic [3:0]  HMASTERS, master_ip;
  hresp_t      HRESPS, resp_ip;
  logic        sel_ip, write_ip, mastlock_ip, held_tran_ip;
  logic        active_ip, readyout_ip;

  // Slave side knobs as percent chance per cycle
  int          act_pct = 100;
  int          rdy_pct = 100;
  int          err_pct = 0;
  int          bus_pct = 100;
  int          starve = 0;       // Cycles in a row without a grant
  logic        bus_ready;        // HREADY of the other slaves
  int unsigned cycle_cnt = 0;

  // Model state
  logic        mdl_pend, mdl_dvalid, mdl_ovr, mdl_bound;
  logic [31:0] hold_addr;
  htrans_t     hold_trans;
  hburst_t     hold_burst;
  hsize_t      hold_size;
  hprot_t      hold_prot;
  logic [3:0]  hold_master;
  logic        hold_write, hold_lock;

  // Expected outputs
  logic        exp_load, exp_held, exp_sel, exp_write, exp_lock, exp_ready;
  logic [31:0] exp_addr;
  htrans_t     base_trans, exp_transb, exp_trans;
  hburst_t     base_burst, exp_burst;
  hsize_t      exp_size;
  hprot_t      exp_prot;
  logic [3:0]  exp_master;
  hresp_t      exp_resp;

  always #10 HCLK = ~HCLK;

  // Bus HREADY is the stage's own ready gated by the rest of the matrix
  assign HREADYS = bus_ready & (HREADYOUTS !== 1'b0);

  ahb_input_stage dut_i (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .HSELS(HSELS), .HADDRS(HADDRS), .HTRANSS(HTRANSS), .HWRITES(HWRITES),
    .HSIZES(HSIZES), .HBURSTS(HBURSTS), .HPROTS(HPROTS), .HMASTERS(HMASTERS),
    .HMASTLOCKS(HMASTLOCKS), .HREADYS(HREADYS), .HREADYOUTS(HREADYOUTS), .HRESPS(HRESPS),
    .sel_ip(sel_ip), .addr_ip(addr_ip), .trans_ip(trans_ip), .write_ip(write_ip),
    .size_ip(size_ip), .burst_ip(burst_ip), .prot_ip(prot_ip), .master_ip(master_ip),
    .mastlock_ip(mastlock_ip), .held_tran_ip(held_tran_ip), .active_ip(active_ip),
    .readyout_ip(readyout_ip), .resp_ip(resp_ip)
  );

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  // True on the last beat of a wrap window
  // Sizes above 64 bits count bytes
  function automatic logic wrap_last(input logic [31:0] addr, input hsize_t size,
                                     input hburst_t burst);
    int unsigned beats;
    int unsigned unit;
    case (burst)
      BUR_WRAP4  : beats = 4;
      BUR_WRAP8  : beats = 8;
      BUR_WRAP16 : beats = 16;
      default    : beats = 0;
    endcase
    unit = (size > 3) ? 1 : (1 << size);
    if (beats == 0)
      return 1'b0;
    return ((addr / unit) % beats) == beats - 1;
  endfunction

  // ----------------------------------------------------------------------
  // Behavioral model
  // ----------------------------------------------------------------------

  always_comb
  begin
    exp_load = HSELS && (HTRANSS == TRN_NONSEQ || HTRANSS == TRN_SEQ) && HREADYS;
    exp_held = exp_load || mdl_pend;
    if (mdl_pend)
    begin
      exp_sel    = 1'b1;
      exp_addr   = hold_addr;
      exp_write  = hold_write;
      exp_size   = hold_size;
      exp_prot   = hold_prot;
      exp_master = hold_master;
      exp_lock   = hold_lock;
      base_trans = TRN_NONSEQ;
      exp_transb = hold_trans;
      base_burst = hold_burst;
    end
    else
    begin
      exp_sel    = HSELS;
      exp_addr   = HADDRS;
      exp_write  = HWRITES;
      exp_size   = HSIZES;
      exp_prot   = HPROTS;
      exp_master = HMASTERS;
      exp_lock   = HMASTLOCKS;
      base_trans = HTRANSS;
      exp_transb = HTRANSS;
      base_burst = HBURSTS;
    end
    exp_trans = base_trans;
    if (mdl_ovr && mdl_bound && base_trans == TRN_SEQ)
      exp_trans = TRN_NONSEQ;
    else if (mdl_ovr && mdl_bound && base_trans == TRN_BUSY)
      exp_trans = TRN_IDLE;
    exp_burst = (mdl_ovr && exp_transb != TRN_NONSEQ) ? BUR_INCR : base_burst;
    if (!mdl_dvalid)
    begin
      exp_ready = 1'b1;
      exp_resp  = RSP_OKAY;
    end
    else if (mdl_pend)
    begin
      exp_ready = 1'b0;      // Master stalled on the held beat
      exp_resp  = RSP_OKAY;
    end
    else
    begin
      exp_ready = readyout_ip;
      exp_resp  = resp_ip;
    end
  end

  always @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      mdl_pend   <= 1'b0;
      mdl_dvalid <= 1'b0;
      mdl_ovr    <= 1'b0;
      mdl_bound  <= 1'b0;
    end
    else
    begin
      if (HREADYS)
        mdl_dvalid <= HSELS && (HTRANSS == TRN_NONSEQ || HTRANSS == TRN_SEQ);
      if (exp_load && !active_ip)
        mdl_pend <= 1'b1;
      else if (active_ip && readyout_ip)
        mdl_pend <= 1'b0;
      if (HREADYS && (HTRANSS == TRN_NONSEQ || HTRANSS == TRN_IDLE))
        mdl_ovr <= 1'b0;
      else if (HREADYS && HTRANSS == TRN_SEQ && exp_load && !active_ip)
        mdl_ovr <= 1'b1;
      if (HREADYS && (HTRANSS == TRN_NONSEQ || HTRANSS == TRN_SEQ))
        mdl_bound <= wrap_last(HADDRS, HSIZES, HBURSTS);
      if (exp_load)
      begin
        hold_addr   <= HADDRS;
        hold_trans  <= HTRANSS;
        hold_burst  <= HBURSTS;
        hold_size   <= HSIZES;
        hold_prot   <= HPROTS;
        hold_master <= HMASTERS;
        hold_write  <= HWRITES;
        hold_lock   <= HMASTLOCKS;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Checks on every edge
  // ----------------------------------------------------------------------

  held_chk: assert property (@(posedge HCLK) disable iff (!HRESETn)
      held_tran_ip === exp_held)
    else stop_on_error($sformatf("CHECK FAILED at %0t: held_tran_ip %b, expected %b",
                                 $time, $sampled(held_tran_ip), $sampled(exp_held)));

  path_chk: assert property (@(posedge HCLK) disable iff (!HRESETn)
      sel_ip === exp_sel && addr_ip === exp_addr && write_ip === exp_write &&
      size_ip === exp_size && prot_ip === exp_prot && master_ip === exp_master &&
      mastlock_ip === exp_lock)
    else stop_on_error($sformatf("CHECK FAILED at %0t: sel/addr %b/%h, expected %b/%h",
                                 $time, $sampled(sel_ip), $sampled(addr_ip),
                                 $sampled(exp_sel), $sampled(exp_addr)));

  trans_chk: assert property (@(posedge HCLK) disable iff (!HRESETn)
      trans_ip === exp_trans)
    else stop_on_error($sformatf("CHECK FAILED at %0t: trans_ip %b, expected %b",
                                 $time, $sampled(trans_ip), $sampled(exp_trans)));

  burst_chk: assert property (@(posedge HCLK) disable iff (!HRESETn)
      burst_ip === exp_burst)
    else stop_on_error($sformatf("CHECK FAILED at %0t: burst_ip %b, expected %b",
                                 $time, $sampled(burst_ip), $sampled(exp_burst)));

  resp_chk: assert property (@(posedge HCLK) disable iff (!HRESETn)
      HREADYOUTS === exp_ready && HRESPS === exp_resp)
    else stop_on_error($sformatf("CHECK FAILED at %0t: HREADYOUTS/HRESPS %b/%b, expected %b/%b",
                                 $time, $sampled(HREADYOUTS), $sampled(HRESPS),
                                 $sampled(exp_ready), $sampled(exp_resp)));

  always @(posedge HCLK)
  begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT)
      stop_on_error($sformatf("Timeout after %0d cycles, stimulus did not finish", cycle_cnt));
  end

  // Output stage and shared slave with a random grant and a starvation limit
  always @(posedge HCLK)
  begin
    #2;
    if (starve >= 3 || ($urandom % 100) < act_pct)
    begin
      active_ip = 1'b1;
      starve    = 0;
    end
    else
    begin
      active_ip = 1'b0;
      starve++;
    end
    readyout_ip = ($urandom % 100) < rdy_pct;
    resp_ip     = (($urandom % 100) < err_pct) ? RSP_ERROR : RSP_OKAY;
    bus_ready   = ($urandom % 100) < bus_pct;
  end

  // ----------------------------------------------------------------------
  // Master side stimulus
  // ----------------------------------------------------------------------

  // Drive one address phase and hold it until the bus moves on
  task automatic issue_beat(input logic sel, input htrans_t trans, input logic [31:0] addr,
                            input hburst_t burst, input hsize_t size);
    logic taken;
    HSELS   = sel;
    HTRANSS = trans;
    HADDRS  = addr;
    HBURSTS = burst;
    HSIZES  = size;
    taken   = 1'b0;
    while (!taken)
    begin
      @(negedge HCLK);
      taken = HREADYS;
      @(posedge HCLK);
      #2;
    end
  endtask

  function automatic logic [31:0] next_addr(input logic [31:0] addr, input hburst_t burst,
                                            input hsize_t size);
    logic [31:0] step;
    logic [31:0] span;
    step = 32'd1 << size;
    case (burst)
      BUR_WRAP4  : span = step * 4;
      BUR_WRAP8  : span = step * 8;
      BUR_WRAP16 : span = step * 16;
      default    : span = 32'd0;
    endcase
    if (span == 0)
      return addr + step;
    return (addr & ~(span - 1)) | ((addr + step) & (span - 1));  // Wrap inside window
  endfunction

  task automatic run_burst(input hburst_t burst, input hsize_t size, input logic [31:0] start,
                           input int beats, input int busy_pct);
    logic [31:0] addr;
    HWRITES    = $urandom % 2;
    HPROTS     = hprot_t'($urandom);
    HMASTERS   = 4'($urandom);
    HMASTLOCKS = ($urandom % 8) == 0;
    addr       = start;
    for (int i = 0; i < beats; i++)
    begin
      if (i > 0 && ($urandom % 100) < busy_pct)
        issue_beat(1'b1, TRN_BUSY, addr, burst, size);
      issue_beat(1'b1, (i == 0) ? TRN_NONSEQ : TRN_SEQ, addr, burst, size);
      addr = next_addr(addr, burst, size);
    end
  endtask

  initial
  begin
    hburst_t     kind;
    hsize_t      size;
    int          len;
    logic [31:0] start;
    void'($urandom(84516));
    HRESETn    = 1'b0;
    HSELS      = 1'b0;
    HADDRS     = '0;
    HTRANSS    = TRN_IDLE;
    HWRITES    = 1'b0;
    HSIZES     = '0;
    HBURSTS    = BUR_SINGLE;
    HPROTS     = '0;
    HMASTERS   = '0;
    HMASTLOCKS = 1'b0;
    // Shared slave waits and errors while the stage leaves reset
    rdy_pct     = 0;
    err_pct     = 100;
    active_ip   = 1'b1;
    readyout_ip = 1'b0;
    resp_ip     = RSP_ERROR;
    bus_ready   = 1'b1;
    repeat (2) @(posedge HCLK);
    #2;
    HRESETn = 1'b1;
    @(negedge HCLK);
    assert (held_tran_ip === 1'b0 && HREADYOUTS === 1'b1 && HRESPS === RSP_OKAY)
      else stop_on_error($sformatf("CHECK FAILED at %0t: outputs not idle after reset", $time));
    rdy_pct = 100;
    err_pct = 0;
    @(posedge HCLK);
    #2;
    // Pass-through with the output stage always granted
    issue_beat(1'b1, TRN_NONSEQ, 32'h100, BUR_SINGLE, 3'd2);
    issue_beat(1'b0, TRN_NONSEQ, 32'h200, BUR_SINGLE, 3'd2);
    issue_beat(1'b1, TRN_IDLE, 32'h0, BUR_SINGLE, 3'd0);
    run_burst(BUR_INCR4, 3'd2, 32'h300, 4, 50);
    // Held single and then interrupted fixed bursts
    act_pct = 0;
    issue_beat(1'b1, TRN_NONSEQ, 32'h400, BUR_SINGLE, 3'd2);
    issue_beat(1'b1, TRN_IDLE, 32'h0, BUR_SINGLE, 3'd0);
    act_pct = 30;
    rdy_pct = 80;
    run_burst(BUR_WRAP4, 3'd2, 32'h48, 4, 30);
    run_burst(BUR_WRAP8, 3'd1, 32'h86, 8, 30);
    run_burst(BUR_WRAP16, 3'd0, 32'h1a5, 16, 20);
    run_burst(BUR_INCR8, 3'd2, 32'h500, 8, 20);
    // Random bursts with grant, wait and error noise
    act_pct = 60;
    err_pct = 5;
    bus_pct = 90;
    repeat (24)
    begin
      kind = hburst_t'($urandom % 8);
      size = hsize_t'($urandom % 5);
      case (kind)
        BUR_SINGLE           : len = 1;
        BUR_INCR             : len = 1 + $urandom % 6;
        BUR_WRAP4, BUR_INCR4 : len = 4;
        BUR_WRAP8, BUR_INCR8 : len = 8;
        default              : len = 16;
      endcase
      start = ($urandom % 4096) & ~((32'd1 << size) - 1);
      run_burst(kind, size, start, len, 20);
      if ($urandom % 3 == 0)
        issue_beat($urandom % 2, TRN_IDLE, 32'h0, BUR_SINGLE, 3'd0);
      else if ($urandom % 2 == 0)
        issue_beat(1'b0, TRN_NONSEQ, 32'h700, BUR_SINGLE, 3'd2);
    end
    // Drain the last held beat
    act_pct = 100;
    rdy_pct = 100;
    err_pct = 0;
    bus_pct = 100;
    repeat (3) issue_beat(1'b1, TRN_IDLE, 32'h0, BUR_SINGLE, 3'd0);
    repeat (3) @(posedge HCLK);
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
common/ahb_pkg.sv
common/instage_pkg.sv
rtl/instage_pend_ctrl.sv
rtl/instage_hold_regs.sv
rtl/instage_burst_term.sv
rtl/ahb_input_stage.sv
dv/tb_ahb_input_stage.sv

// ==== Bender.yml ====
package:
  name: ahb_input_stage

sources:
  - common/ahb_pkg.sv
  - common/instage_pkg.sv
  - rtl/instage_pend_ctrl.sv
  - rtl/instage_hold_regs.sv
  - rtl/instage_burst_term.sv
  - rtl/ahb_input_stage.sv
  - target: test
    files:
      - dv/tb_ahb_input_stage.sv
